// File: common/seq_pkg.sv
package seq_pkg;

   localparam int inst_width     = 20;
   localparam int addr_width     = 8;
   localparam int prog_depth     = 256;
   localparam int num_iregs      = 4;
   localparam int num_devices    = 8;
   localparam int cmd_fifo_depth = 4;

   // any code above op_wn is illegal and stops the sequencer
   typedef enum logic [3:0] {
      op_no = 4'd0,
      op_ci = 4'd1,
      op_cr = 4'd2,
      op_ji = 4'd3,
      op_jr = 4'd4,
      op_jz = 4'd5,
      op_jn = 4'd6,
      op_wz = 4'd7,
      op_wn = 4'd8
   } opcode_t;

   typedef enum logic [2:0] {
      st_reset,
      st_ready,
      st_wait_z,
      st_wait_n,
      st_error
   } seq_state_t;

   // hi is the jump label, or {spare, dev[2:0], cmd[3:0]} for commands
   // lo is the immediate argument; lo[1:0] picks the status input
   typedef struct packed {
      opcode_t    code;
      logic [7:0] hi;
      logic [7:0] lo;
   } inst_t;

   typedef logic [num_iregs-1:0][7:0] ireg_t;

   typedef struct packed {
      logic [3:0]             cmd;
      logic [7:0]             arg;
      logic [num_devices-1:0] sel;   // one-hot device
   } dev_cmd_t;

   function automatic logic [$clog2(num_devices)-1:0] inst_dev(inst_t i);
      return i.hi[6:4];
   endfunction

   function automatic logic [3:0] inst_cmd(inst_t i);
      return i.hi[3:0];
   endfunction

   function automatic logic [addr_width-1:0] inst_label(inst_t i);
      return i.hi;
   endfunction

   function automatic logic [$clog2(num_iregs)-1:0] inst_src(inst_t i);
      return i.lo[1:0];
   endfunction

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# compile with Verilator, run, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f seq_system.f \
   --top-module seq_system_tb -o seq_system_sim
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/seq_system_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "Test OK" sim.log; then
   exit 0
fi
echo "pass line not found in sim.log"
exit 1

// File: seq/seq_core.sv
`timescale 1ns/1ps

module seq_core
   import seq_pkg::*;
(
   input  logic                  clock,
   input  logic                  reset,
   input  inst_t                 inst,
   input  logic                  inst_valid,
   input  ireg_t                 ireg,
   input  logic                  cmd_hold,
   output logic [addr_width-1:0] pc,
   output dev_cmd_t              cmd,
   output logic                  cmd_push,
   output logic                  seq_error
);

   seq_state_t             state;
   logic [7:0]             src_val;
   logic                   src_zero;
   logic [num_devices-1:0] dev_sel;
   logic                   exec;

   // status input picked by the source field
   assign src_val  = ireg[inst_src(inst)];
   assign src_zero = (src_val == 8'd0);
   assign dev_sel  = num_devices'(1) << inst_dev(inst);

   // one instruction per cycle unless the word is missing or the FIFO is near full
   assign exec = (state == st_ready) && inst_valid && !cmd_hold;

   assign seq_error = (state == st_error);

   always_ff @(posedge clock) begin
      if (reset) begin
         state    <= st_reset;
         pc       <= '0;
         cmd_push <= 1'b0;
      end else begin
         cmd_push <= 1'b0;   // strobe
         case (state)
            st_reset: begin
               state <= st_ready;
            end
            st_ready: begin
               if (exec) begin
                  case (inst.code)
                     op_no: pc <= pc + 1'b1;
                     op_ci, op_cr: begin
                        pc       <= pc + 1'b1;
                        cmd_push <= 1'b1;
                     end
                     op_ji: pc <= inst_label(inst);
                     op_jr: pc <= src_val;
                     op_jz: pc <= src_zero ? inst_label(inst) : pc + 1'b1;
                     op_jn: pc <= !src_zero ? inst_label(inst) : pc + 1'b1;
                     op_wz: begin
                        if (src_zero) begin
                           pc <= pc + 1'b1;   // already met, no wait cycle
                        end else begin
                           state <= st_wait_z;
                        end
                     end
                     op_wn: begin
                        if (!src_zero) begin
                           pc <= pc + 1'b1;
                        end else begin
                           state <= st_wait_n;
                        end
                     end
                     default: begin
                        state <= st_error;
                        pc    <= '0;
                     end
                  endcase
               end
            end
            // pc still points at the wait, so inst gives the same source
            st_wait_z: begin
               if (src_zero) begin
                  state <= st_ready;
                  pc    <= pc + 1'b1;
               end
            end
            st_wait_n: begin
               if (!src_zero) begin
                  state <= st_ready;
                  pc    <= pc + 1'b1;
               end
            end
            st_error: pc <= '0;   // stays here until reset
            default: begin
               state <= st_error;
               pc    <= '0;
            end
         endcase
      end
   end

   // command payload, qualified by cmd_push
   always_ff @(posedge clock) begin
      if (exec) begin
         cmd.cmd <= inst_cmd(inst);
         cmd.arg <= (inst.code == op_cr) ? src_val : inst.lo;
         cmd.sel <= dev_sel;
      end
   end

   a_push_onehot: assert property (@(posedge clock) disable iff (reset)
      cmd_push |-> $onehot(cmd.sel));

   a_no_push_in_error: assert property (@(posedge clock) disable iff (reset)
      (state == st_error) |=> !cmd_push);

endmodule

// File: seq/seq_program.sv
`timescale 1ns/1ps

module seq_program
   import seq_pkg::*;
(
   input  logic                  clock,
   input  logic                  reset,
   input  logic                  prog_we,
   input  logic [addr_width-1:0] prog_addr,
   input  inst_t                 prog_data,
   input  logic [addr_width-1:0] pc,
   output inst_t                 inst,
   output logic                  inst_valid
);

   logic [inst_width-1:0] mem [prog_depth];
   logic [prog_depth-1:0] valid;   // one bit per word, set on write

   always_ff @(posedge clock) begin
      if (prog_we) begin
         mem[prog_addr] <= prog_data;
      end
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         valid <= '0;
      end else if (prog_we) begin
         valid[prog_addr] <= 1'b1;
      end
   end

   // fetch in the same cycle, no read register
   assign inst       = inst_t'(mem[pc]);
   assign inst_valid = valid[pc];   // unwritten word stalls the core

endmodule

// File: seq_system.f
common/seq_pkg.sv
seq/seq_program.sv
seq/seq_core.sv
verilog/cmd_fifo.sv
verilog/cmd_serializer.sv
verilog/seq_system.sv
verification/seq_system_tb.sv

// File: verification/seq_system_tb.sv
`timescale 1ns/1ps

module seq_system_tb
   import seq_pkg::*;
();

   localparam int wait_limit = 300;   // cycles allowed per wait

   logic                   clock;
   logic                   reset;
   logic                   prog_we;
   logic [addr_width-1:0]  prog_addr;
   inst_t                  prog_data;
   ireg_t                  ireg;
   logic [addr_width-1:0]  pc;
   logic                   seq_error;
   logic                   link_start;
   logic [3:0]             link_data;
   logic [num_devices-1:0] link_sel;

   int       seed;
   int       col_nib;
   dev_cmd_t col_frame;
   dev_cmd_t got_q [$];   // frames seen on the link
   dev_cmd_t exp_q [$];   // frames in execution order
   inst_t    image [prog_depth];
   logic     defined [prog_depth];

   seq_system dut0 (.*);

   initial begin
      clock = 1'b0;
      forever #2 clock = ~clock;
   end

   task automatic value_error(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      $display("Test FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic rule_error(input string what);
      $display("** Error at %0t ns: %s", $time, what);
      $display("Test FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic timeout_error(input string what);
      $display("Timeout at %0t ns: waited %0d cycles for %s", $time, wait_limit, what);
      $display("Test FAILED");
      $fatal(1, "wait expired");
   endtask

   // framing rules of the link
   a_start_onehot: assert property (@(posedge clock) disable iff (reset)
      link_start |-> $onehot(link_sel))
      else rule_error("link_sel is not one-hot at frame start");
   a_second_nib: assert property (@(posedge clock) disable iff (reset)
      $past(link_start) |-> (!link_start && link_sel == $past(link_sel)))
      else rule_error("frame broken in its second nibble cycle");
   a_third_nib: assert property (@(posedge clock) disable iff (reset)
      $past(link_start, 2) |-> (!link_start && link_sel == $past(link_sel, 2)))
      else rule_error("frame broken in its third nibble cycle");
   a_sel_idle: assert property (@(posedge clock) disable iff (reset)
      (!link_start && !$past(link_start) && !$past(link_start, 2)) |-> link_sel == '0)
      else rule_error("link_sel active outside a frame");

   // collects three nibbles into one frame
   always @(negedge clock) begin
      if (reset) begin
         col_nib = 0;
      end else if (link_start) begin
         col_frame.cmd = link_data;
         col_frame.sel = link_sel;
         col_nib       = 1;
      end else if (col_nib == 1) begin
         col_frame.arg[7:4] = link_data;
         col_nib            = 2;
      end else if (col_nib == 2) begin
         col_frame.arg[3:0] = link_data;
         got_q.push_back(col_frame);
         col_nib = 0;
      end
   end

   function automatic logic [7:0] rand8();
      int r;
      r = $random(seed);
      return r[7:0];
   endfunction

   function automatic inst_t encode(opcode_t code, logic [7:0] hi, logic [7:0] lo);
      inst_t i;
      i.code = code;
      i.hi   = hi;
      i.lo   = lo;
      return i;
   endfunction

   task automatic put_inst(input logic [7:0] addr, input inst_t i);
      image[addr]   = i;
      defined[addr] = 1'b1;
   endtask

   // ci sends lo, cr sends the status picked by lo[1:0]
   task automatic put_cmd(input logic [7:0] addr, input opcode_t code, input logic [2:0] dev,
                          input logic [3:0] cmd, input logic [7:0] lo);
      dev_cmd_t f;
      put_inst(addr, encode(code, {1'b0, dev, cmd}, lo));
      f.cmd = cmd;
      f.arg = (code == op_cr) ? ireg[lo[1:0]] : lo;
      f.sel = 8'(1) << dev;
      exp_q.push_back(f);
   endtask

   // built in execution order
   // markers carry their own address as arg
   task automatic build_program();
      int a;
      for (a = 0; a < 6; a++) begin
         put_cmd(8'(a), op_ci, 3'(a), 4'(rand8()), rand8());
      end
      for (a = 6; a < 10; a++) begin
         put_cmd(8'(a), op_cr, 3'(a), 4'(rand8()), {6'(rand8()), 2'(a - 6)});
      end
      put_inst(8'd10, encode(op_ji, 8'd20, 8'h00));
      put_cmd(8'd20, op_ci, 3'd4, 4'(rand8()), 8'd20);
      put_inst(8'd21, encode(op_jz, 8'd30, 8'h01));    // status 1 is zero so taken
      put_cmd(8'd30, op_ci, 3'd5, 4'(rand8()), 8'd30);
      put_inst(8'd31, encode(op_jz, 8'd200, 8'h00));   // falls through
      put_cmd(8'd32, op_ci, 3'd6, 4'(rand8()), 8'd32);
      put_inst(8'd33, encode(op_jn, 8'd40, 8'h00));
      put_cmd(8'd40, op_ci, 3'd7, 4'(rand8()), 8'd40);
      put_inst(8'd41, encode(op_jn, 8'd200, 8'h01));
      put_cmd(8'd42, op_ci, 3'd0, 4'(rand8()), 8'd42);
      put_inst(8'd43, encode(op_jr, 8'h00, 8'h03));    // to ireg[3]
      put_cmd(8'd80, op_ci, 3'd1, 4'(rand8()), 8'd80);
      put_inst(8'd81, encode(op_wz, 8'h00, 8'h02));
      put_cmd(8'd82, op_ci, 3'd2, 4'(rand8()), 8'd82);
      put_inst(8'd83, encode(op_wn, 8'h00, 8'h01));
      put_cmd(8'd84, op_ci, 3'd3, 4'(rand8()), 8'd84);
      put_inst(8'd85, inst_t'({4'hf, 16'h0000}));      // illegal opcode
   endtask

   task automatic write_word(input logic [7:0] addr);
      @(negedge clock);
      prog_we   = 1'b1;
      prog_addr = addr;
      prog_data = image[addr];
   endtask

   // first word last, so execution starts on a complete block
   task automatic load_range(input int lo, input int hi);
      int a;
      for (a = lo + 1; a <= hi; a++) begin
         if (defined[a]) begin
            write_word(8'(a));
         end
      end
      write_word(8'(lo));
      @(negedge clock);
      prog_we = 1'b0;
   endtask

   task automatic expect_frames(input int n, input string what);
      int       cycles;
      dev_cmd_t got;
      dev_cmd_t exp;
      cycles = 0;
      while (got_q.size() < n) begin
         @(posedge clock);
         cycles++;
         if (cycles > wait_limit) timeout_error(what);
      end
      repeat (n) begin
         got = got_q.pop_front();
         exp = exp_q.pop_front();
         assert (got.cmd == exp.cmd) else value_error("frame cmd", 32'(got.cmd), 32'(exp.cmd));
         assert (got.arg == exp.arg) else value_error("frame arg", 32'(got.arg), 32'(exp.arg));
         assert (got.sel == exp.sel) else value_error("frame sel", 32'(got.sel), 32'(exp.sel));
      end
   endtask

   task automatic wait_pc(input logic [7:0] target, input string what);
      int cycles;
      cycles = 0;
      @(negedge clock);
      while (pc != target) begin
         cycles++;
         if (cycles > wait_limit) timeout_error(what);
         @(negedge clock);
      end
   endtask

   task automatic wait_error(input string what);
      int cycles;
      cycles = 0;
      @(negedge clock);
      while (!seq_error) begin
         cycles++;
         if (cycles > wait_limit) timeout_error(what);
         @(negedge clock);
      end
   endtask

   // pc parked, link quiet, nothing collected
   task automatic watch_idle(input int cycles, input logic [7:0] exp_pc, input logic exp_err);
      repeat (cycles) begin
         @(negedge clock);
         assert (pc == exp_pc) else value_error("pc", 32'(pc), 32'(exp_pc));
         assert (seq_error == exp_err)
            else value_error("seq_error", 32'(seq_error), 32'(exp_err));
         assert (!link_start) else rule_error("a frame started while the link should be idle");
         assert (link_sel == '0) else value_error("link_sel", 32'(link_sel), 32'd0);
      end
      @(posedge clock);
      assert (got_q.size() == 0) else rule_error("a frame was collected while idle");
   endtask

   initial begin
      seed      = 32'h83f9;
      reset     = 1'b1;
      prog_we   = 1'b0;
      prog_addr = '0;
      prog_data = '0;
      ireg[0]   = rand8() | 8'h01;   // non-zero
      ireg[1]   = 8'h00;
      ireg[2]   = rand8() | 8'h01;   // holds the wz at 81
      ireg[3]   = 8'd80;
      foreach (defined[i]) begin
         defined[i] = 1'b0;
      end
      repeat (16) @(negedge clock);
      reset = 1'b0;

      watch_idle(20, 8'd0, 1'b0);   // no valid word yet

      build_program();
      load_range(0, 43);
      expect_frames(15, "the burst, cr and branch frames");
      wait_pc(8'd80, "pc to stall on the unwritten jr target");
      watch_idle(20, 8'd80, 1'b0);

      load_range(80, 85);
      expect_frames(1, "the frame before wz");
      wait_pc(8'd81, "pc to reach wz");
      watch_idle(20, 8'd81, 1'b0);
      @(negedge clock);
      ireg[2] = 8'h00;
      expect_frames(1, "the frame after wz is released");
      wait_pc(8'd83, "pc to reach wn");
      watch_idle(20, 8'd83, 1'b0);
      @(negedge clock);
      ireg[1] = rand8() | 8'h01;
      expect_frames(1, "the frame after wn is released");
      wait_error("seq_error after the illegal opcode");
      watch_idle(30, 8'd0, 1'b1);

      $display("Test OK");
      $finish;
   end

endmodule

// File: verilog/cmd_fifo.sv
`timescale 1ns/1ps

module cmd_fifo
   import seq_pkg::*;
#(
   parameter type payload_t = logic [7:0]
)
(
   input  logic     clock,
   input  logic     reset,
   input  logic     push,
   input  payload_t din,
   input  logic     pop,
   output payload_t head,
   output logic     empty,
   output logic     hold
);

   payload_t                              mem [cmd_fifo_depth];
   logic [$clog2(cmd_fifo_depth)-1:0]     rd_ptr;
   logic [$clog2(cmd_fifo_depth)-1:0]     wr_ptr;
   logic [$clog2(cmd_fifo_depth + 1)-1:0] count;
   logic                                  full;

   assign empty = (count == 0);
   assign full  = (count == cmd_fifo_depth);
   // one slot kept free for the push already registered upstream
   assign hold  = (count >= cmd_fifo_depth - 1);
   assign head  = mem[rd_ptr];

   always_ff @(posedge clock) begin
      if (push) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == cmd_fifo_depth - 1) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == cmd_fifo_depth - 1) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // both or neither
         endcase
      end
   end

   a_no_overflow: assert property (@(posedge clock) disable iff (reset)
      push |-> !full);

   a_no_underflow: assert property (@(posedge clock) disable iff (reset)
      pop |-> !empty);

endmodule

// File: verilog/cmd_serializer.sv
`timescale 1ns/1ps

module cmd_serializer
   import seq_pkg::*;
(
   input  logic                   clock,
   input  logic                   reset,
   input  logic                   empty,
   input  dev_cmd_t               head,
   output logic                   pop,
   output logic                   link_start,
   output logic [3:0]             link_data,
   output logic [num_devices-1:0] link_sel
);

   logic                   busy;
   logic [1:0]             nib;      // 0 cmd, 1 arg high, 2 arg low
   logic [11:0]            shreg;    // {cmd, arg}, top nibble on the link
   logic [num_devices-1:0] sel_q;

   // take the next command when idle or on the last nibble
   assign pop = !empty && (!busy || nib == 2'd2);

   assign link_start = busy && (nib == 2'd0);
   assign link_data  = shreg[11:8];
   assign link_sel   = busy ? sel_q : '0;

   always_ff @(posedge clock) begin
      if (reset) begin
         busy <= 1'b0;
         nib  <= 2'd0;
      end else if (pop) begin
         busy <= 1'b1;
         nib  <= 2'd0;
      end else if (busy) begin
         if (nib == 2'd2) begin
            busy <= 1'b0;   // frame done, nothing waiting
            nib  <= 2'd0;
         end else begin
            nib <= nib + 1'b1;
         end
      end
   end

   always_ff @(posedge clock) begin
      if (pop) begin
         shreg <= {head.cmd, head.arg};
         sel_q <= head.sel;
      end else begin
         shreg <= shreg << 4;
      end
   end

   a_sel_onehot0: assert property (@(posedge clock) disable iff (reset)
      $onehot0(link_sel));

endmodule

// File: verilog/seq_system.sv
`timescale 1ns/1ps

module seq_system
   import seq_pkg::*;
(
   input  logic                   clock,
   input  logic                   reset,
   input  logic                   prog_we,
   input  logic [addr_width-1:0]  prog_addr,
   input  inst_t                  prog_data,
   input  ireg_t                  ireg,
   output logic [addr_width-1:0]  pc,
   output logic                   seq_error,
   output logic                   link_start,
   output logic [3:0]             link_data,
   output logic [num_devices-1:0] link_sel
);

   inst_t    inst;
   logic     inst_valid;
   dev_cmd_t cmd;
   logic     cmd_push;
   logic     cmd_hold;
   dev_cmd_t fifo_head;
   logic     fifo_empty;
   logic     fifo_pop;

   seq_program u_program (
      .clock      (clock),
      .reset      (reset),
      .prog_we    (prog_we),
      .prog_addr  (prog_addr),
      .prog_data  (prog_data),
      .pc         (pc),
      .inst       (inst),
      .inst_valid (inst_valid)
   );

   seq_core u_core (
      .clock      (clock),
      .reset      (reset),
      .inst       (inst),
      .inst_valid (inst_valid),
      .ireg       (ireg),
      .cmd_hold   (cmd_hold),
      .pc         (pc),
      .cmd        (cmd),
      .cmd_push   (cmd_push),
      .seq_error  (seq_error)
   );

   cmd_fifo #(
      .payload_t (dev_cmd_t)
   ) u_fifo (
      .clock (clock),
      .reset (reset),
      .push  (cmd_push),
      .din   (cmd),
      .pop   (fifo_pop),
      .head  (fifo_head),
      .empty (fifo_empty),
      .hold  (cmd_hold)
   );

   cmd_serializer u_serializer (
      .clock      (clock),
      .reset      (reset),
      .empty      (fifo_empty),
      .head       (fifo_head),
      .pop        (fifo_pop),
      .link_start (link_start),
      .link_data  (link_data),
      .link_sel   (link_sel)
   );

endmodule
